/* ctu_params.svh */
// CTU widths, register address map, reset values and CTRL bit positions
`ifndef CTU_PARAMS_SVH
`define CTU_PARAMS_SVH

// ------------------------------
// Widths
// ------------------------------

// Slow-clock divide ratio field
`define CTU_RATIO_W         4
// One enable per gated cluster
`define CTU_NUM_CKEN        8
// External asynchronous pins
`define CTU_NUM_PIN         4
// APB byte address, word aligned
`define CTU_ADDR_W          4
// CTRL register field
`define CTU_CTRL_W          2

// ------------------------------
// Register map
// ------------------------------
`define CTU_ADDR_RATIO      4'h0
`define CTU_ADDR_CKEN       4'h4
`define CTU_ADDR_CTRL       4'h8
`define CTU_ADDR_STATUS     4'hC

// Reset value of RATIO
`define CTU_RATIO_RST       4

// CTRL bits
`define CTU_CTRL_START_BIT  0
`define CTU_CTRL_FORCE_BIT  1

`endif

/* ctu_pkg.sv */
// CTU shared types: APB request, register command, sync pulses, clock enables
`include "ctu_params.svh"

package ctu_pkg;

   // Clock-enable vector, one bit per cluster
   typedef logic [`CTU_NUM_CKEN-1:0] cken_t;

   // Readable registers, in address order
   typedef enum logic [1:0] {
      RD_RATIO  = 2'd0,
      RD_CKEN   = 2'd1,
      RD_CTRL   = 2'd2,
      RD_STATUS = 2'd3
   } rd_sel_e;

   // APB request as driven by the master
   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`CTU_ADDR_W-1:0] paddr;
      logic [31:0]            pwdata;
   } apb_req_t;

   // Decoded command, valid one cycle in the first access cycle
   typedef struct packed {
      logic        wr_ratio;
      logic        wr_cken;
      logic        wr_ctrl;
      rd_sel_e     rd_sel;
      logic        access;
      logic        err;
      logic [31:0] wdata;
   } reg_cmd_t;

   // Slow-domain phase markers
   typedef struct packed {
      logic rx_sync;
      logic coin_edge;
   } sync_pulse_t;

endpackage

/* ctu_sync_pulse_gen.sv */
// Ratio counter that produces the rx_sync and coin_edge pulses of the slow domain
`include "ctu_params.svh"

module ctu_sync_pulse_gen (
   input  logic                    cmp_clk,
   input  logic                    reset,
   input  logic [`CTU_RATIO_W-1:0] ratio,
   output ctu_pkg::sync_pulse_t    sync_pulse
);

   // Shortest legal period is two fast cycles
   localparam logic [`CTU_RATIO_W-1:0] RATIO_MIN = 2;

   logic [`CTU_RATIO_W-1:0] ratio_clamp;
   logic [`CTU_RATIO_W-1:0] cnt;
   logic [`CTU_RATIO_W-1:0] cnt_nxt;
   logic                    wrap;

   // ------------------------------
   // Phase counter
   // ------------------------------

   // Ratios 0 and 1 run as 2
   assign ratio_clamp = (ratio < RATIO_MIN) ? RATIO_MIN : ratio;

   // Down count that reaches zero in the last fast cycle of a slow period
   assign wrap = (cnt == '0);

   // New ratio only taken at the wrap
   assign cnt_nxt = wrap ? (ratio_clamp - 1'b1) : (cnt - 1'b1);

   // Pulses line up with the counter value they mark
   // rx_sync marks the first cycle with the count just loaded
   // coin_edge marks the last cycle where fast and slow edges coincide
   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         cnt        <= '0;
         sync_pulse <= '0;
      end else begin
         cnt                  <= cnt_nxt;
         sync_pulse.rx_sync   <= wrap;
         sync_pulse.coin_edge <= (cnt_nxt == '0);
      end
   end

endmodule

/* ctu_synch_stage.sv */
// Capture on rx_sync and release on coin_edge crossing into the slow domain
module ctu_synch_stage #(
   parameter type payload_t = ctu_pkg::cken_t
) (
   input  logic                 cmp_clk,
   input  logic                 reset,
   input  ctu_pkg::sync_pulse_t sync_pulse,
   input  payload_t             presyncdata,
   output payload_t             syncdata
);

   payload_t hold_q;

   // Sample at start of slow period, later captures overwrite
   always_ff @(posedge cmp_clk) begin
      if (sync_pulse.rx_sync) begin
         hold_q <= presyncdata;
      end
   end

   // Release on the coincident edge only, so the slow side
   // sees a value that was stable for the whole period
   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         syncdata <= '0;
      end else if (sync_pulse.coin_edge) begin
         syncdata <= hold_q;
      end
   end

endmodule

/* ctu_synchronizer.sv */
// Two-flop synchronizer for asynchronous input pins
module ctu_synchronizer #(
   parameter int SIZE = 1
) (
   input  logic            cmp_clk,
   input  logic            reset,
   input  logic [SIZE-1:0] presyncdata,
   output logic [SIZE-1:0] syncdata
);

   // First stage may go metastable
   logic [SIZE-1:0] meta_q;

   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         meta_q   <= '0;
         syncdata <= '0;
      end else begin
         meta_q   <= presyncdata;
         syncdata <= meta_q;
      end
   end

endmodule

/* ctu_apb_decode.sv */
// APB front end decoding address and phase into register commands and errors
`include "ctu_params.svh"

module ctu_apb_decode (
   input  logic              cmp_clk,
   input  logic              reset,
   input  ctu_pkg::apb_req_t apb_req,
   output ctu_pkg::reg_cmd_t reg_cmd
);

   import ctu_pkg::*;

   logic     setup;
   logic     wr;
   reg_cmd_t cmd_nxt;

   // Setup phase, registered so the command lands in the first access cycle
   assign setup = apb_req.psel & ~apb_req.penable;
   assign wr    = setup & apb_req.pwrite;

   // ------------------------------
   // Address decode
   // ------------------------------
   always_comb begin
      cmd_nxt        = '0;
      cmd_nxt.access = setup;
      cmd_nxt.wdata  = apb_req.pwdata;
      cmd_nxt.rd_sel = RD_RATIO;
      case (apb_req.paddr)
         `CTU_ADDR_RATIO: begin
            cmd_nxt.rd_sel   = RD_RATIO;
            cmd_nxt.wr_ratio = wr;
         end
         `CTU_ADDR_CKEN: begin
            cmd_nxt.rd_sel  = RD_CKEN;
            cmd_nxt.wr_cken = wr;
         end
         `CTU_ADDR_CTRL: begin
            cmd_nxt.rd_sel  = RD_CTRL;
            cmd_nxt.wr_ctrl = wr;
         end
         `CTU_ADDR_STATUS: begin
            // Read only
            cmd_nxt.rd_sel = RD_STATUS;
            cmd_nxt.err    = wr;
         end
         default: begin
            // Unmapped, no strobe either way
            cmd_nxt.err = setup;
         end
      endcase
   end

   // One-cycle command pulse
   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         reg_cmd <= '0;
      end else begin
         reg_cmd <= cmd_nxt;
      end
   end

endmodule

/* ctu_cken_ctl.sv */
// RATIO, CKEN and CTRL registers with the registered start and force mux
`include "ctu_params.svh"

module ctu_cken_ctl (
   input  logic                    cmp_clk,
   input  logic                    reset,
   input  ctu_pkg::reg_cmd_t       reg_cmd,
   output logic [`CTU_RATIO_W-1:0] ratio,
   output ctu_pkg::cken_t          cken_reg,
   output logic [`CTU_CTRL_W-1:0]  ctrl,
   output ctu_pkg::cken_t          cken_cl
);

   logic start_clk;
   logic force_cken;

   // ------------------------------
   // Software registers
   // ------------------------------

   // Updated on the edge that ends the first access cycle
   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         ratio    <= `CTU_RATIO_W'(`CTU_RATIO_RST);
         cken_reg <= '0;
         ctrl     <= '0;
      end else begin
         if (reg_cmd.wr_ratio) begin
            ratio <= reg_cmd.wdata[`CTU_RATIO_W-1:0];
         end
         if (reg_cmd.wr_cken) begin
            cken_reg <= reg_cmd.wdata[`CTU_NUM_CKEN-1:0];
         end
         if (reg_cmd.wr_ctrl) begin
            ctrl <= reg_cmd.wdata[`CTU_CTRL_W-1:0];
         end
      end
   end

   assign start_clk  = ctrl[`CTU_CTRL_START_BIT];
   assign force_cken = ctrl[`CTU_CTRL_FORCE_BIT];

   // ------------------------------
   // Fast-domain clock enables
   // ------------------------------

   // Force wins, otherwise mask held off until start
   // Registered so the enable tree sees a clean flop output
   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         cken_cl <= '0;
      end else if (force_cken) begin
         cken_cl <= '1;
      end else if (start_clk) begin
         cken_cl <= cken_reg;
      end else begin
         cken_cl <= '0;
      end
   end

endmodule

/* ctu_status_rd.sv */
// Read data mux and APB response with one wait state
`include "ctu_params.svh"

module ctu_status_rd (
   input  logic                    cmp_clk,
   input  logic                    reset,
   input  ctu_pkg::reg_cmd_t       reg_cmd,
   input  logic [`CTU_RATIO_W-1:0] ratio,
   input  ctu_pkg::cken_t          cken_reg,
   input  logic [`CTU_CTRL_W-1:0]  ctrl,
   input  logic [`CTU_NUM_PIN-1:0] pin_sync,
   output logic [31:0]             prdata,
   output logic                    pready,
   output logic                    pslverr
);

   import ctu_pkg::*;

   logic [31:0] rd_data;

   // Unmapped reads return zero
   always_comb begin
      rd_data = '0;
      if (!reg_cmd.err) begin
         case (reg_cmd.rd_sel)
            RD_RATIO:  rd_data = 32'(ratio);
            RD_CKEN:   rd_data = 32'(cken_reg);
            RD_CTRL:   rd_data = 32'(ctrl);
            RD_STATUS: rd_data = 32'(pin_sync);
            default:   rd_data = '0;
         endcase
      end
   end

   // Sampled at command time, before any write in the same access lands
   always_ff @(posedge cmp_clk) begin
      if (reg_cmd.access) begin
         prdata <= rd_data;
      end
   end

   // Response in the second access cycle
   always_ff @(posedge cmp_clk) begin
      if (reset) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= reg_cmd.access;
         pslverr <= reg_cmd.access & reg_cmd.err;
      end
   end

endmodule

/* ctu_top.sv */
// CTU top level wiring APB decode, registers, pulse generator and crossings
`include "ctu_params.svh"

module ctu_top (
   input  logic                    cmp_clk,
   input  logic                    reset,
   input  ctu_pkg::apb_req_t       apb_req,
   input  logic [`CTU_NUM_PIN-1:0] pins,
   output logic [31:0]             prdata,
   output logic                    pready,
   output logic                    pslverr,
   output ctu_pkg::cken_t          cken_cl,
   output ctu_pkg::cken_t          cken_jl,
   output logic [`CTU_CTRL_W-1:0]  ctrl_jl,
   output ctu_pkg::sync_pulse_t    sync_pulse
);

   import ctu_pkg::*;

   reg_cmd_t                reg_cmd;
   logic [`CTU_RATIO_W-1:0] ratio;
   cken_t                   cken_reg;
   logic [`CTU_CTRL_W-1:0]  ctrl;
   logic [`CTU_NUM_PIN-1:0] pin_sync;

   // ------------------------------
   // Register path
   // ------------------------------
   ctu_apb_decode u_apb_decode (
      .cmp_clk (cmp_clk),
      .reset   (reset),
      .apb_req (apb_req),
      .reg_cmd (reg_cmd)
   );

   ctu_cken_ctl u_cken_ctl (
      .cmp_clk  (cmp_clk),
      .reset    (reset),
      .reg_cmd  (reg_cmd),
      .ratio    (ratio),
      .cken_reg (cken_reg),
      .ctrl     (ctrl),
      .cken_cl  (cken_cl)
   );

   ctu_status_rd u_status_rd (
      .cmp_clk  (cmp_clk),
      .reset    (reset),
      .reg_cmd  (reg_cmd),
      .ratio    (ratio),
      .cken_reg (cken_reg),
      .ctrl     (ctrl),
      .pin_sync (pin_sync),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr)
   );

   // Async pins into cmp_clk
   ctu_synchronizer #(.SIZE(`CTU_NUM_PIN)) u_pin_sync (
      .cmp_clk     (cmp_clk),
      .reset       (reset),
      .presyncdata (pins),
      .syncdata    (pin_sync)
   );

   // ------------------------------
   // Slow-domain crossing
   // ------------------------------
   ctu_sync_pulse_gen u_sync_pulse_gen (
      .cmp_clk    (cmp_clk),
      .reset      (reset),
      .ratio      (ratio),
      .sync_pulse (sync_pulse)
   );

   // Enables after the start and force mux
   ctu_synch_stage #(.payload_t(cken_t)) u_synch_cken (
      .cmp_clk     (cmp_clk),
      .reset       (reset),
      .sync_pulse  (sync_pulse),
      .presyncdata (cken_cl),
      .syncdata    (cken_jl)
   );

   // Raw CTRL bits for slow-side logic
   ctu_synch_stage #(.payload_t(logic [`CTU_CTRL_W-1:0])) u_synch_ctrl (
      .cmp_clk     (cmp_clk),
      .reset       (reset),
      .sync_pulse  (sync_pulse),
      .presyncdata (ctrl),
      .syncdata    (ctrl_jl)
   );

endmodule

/* ctu_asserts.sv */
// Bound checks on sync pulse spacing, APB pready width and slow-domain crossing
`include "ctu_params.svh"

module ctu_asserts (
   input logic                    cmp_clk,
   input logic                    reset,
   input logic [`CTU_RATIO_W-1:0] ratio,
   input ctu_pkg::sync_pulse_t    sync_pulse,
   input logic                    pready,
   input ctu_pkg::cken_t          cken_jl
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [`CTU_RATIO_W-1:0] MIN_R = 2;

   logic                    rx;
   logic                    coin;
   logic [`CTU_RATIO_W-1:0] ratio_clamp;
   // Period in force, taken at each coin_edge
   logic [`CTU_RATIO_W-1:0] per_q;
   // Cycles since the last rx_sync
   logic [`CTU_RATIO_W:0]   gap;

   assign rx          = sync_pulse.rx_sync;
   assign coin        = sync_pulse.coin_edge;
   assign ratio_clamp = (ratio < MIN_R) ? MIN_R : ratio;

   always @(posedge cmp_clk) begin
      if (reset) begin
         gap   <= '0;
         per_q <= `CTU_RATIO_W'(`CTU_RATIO_RST);
      end else begin
         gap <= rx ? (`CTU_RATIO_W+1)'(1) : gap + 1'b1;
         if (coin) begin
            per_q <= ratio_clamp;
         end
      end
   end

   // ------------------------------
   // Properties
   // ------------------------------

   // coin_edge closes a period of the clamped ratio
   a_pulse_gap: assert property (@(posedge cmp_clk) disable iff (reset)
      coin |-> (gap == {1'b0, per_q} - 1'b1))
      else $error("coin_edge spacing does not match the ratio");

   // Next period starts right after coin_edge
   a_rx_follows: assert property (@(posedge cmp_clk) disable iff (reset)
      coin |=> rx)
      else $error("rx_sync missing after coin_edge");

   // Single-cycle APB response
   a_pready_one: assert property (@(posedge cmp_clk) disable iff (reset)
      pready |=> !pready)
      else $error("pready held longer than one cycle");

   // Slow-side enables move only on a coincident edge
   a_jl_stable: assert property (@(posedge cmp_clk) disable iff (reset)
      (cken_jl != $past(cken_jl)) |-> $past(coin))
      else $error("cken_jl changed without coin_edge");

endmodule

bind ctu_top ctu_asserts u_asserts (
   .cmp_clk    (cmp_clk),
   .reset      (reset),
   .ratio      (ratio),
   .sync_pulse (sync_pulse),
   .pready     (pready),
   .cken_jl    (cken_jl)
);

/* ctu_tb.sv */
// CTU testbench with random APB and pin stimulus, cycle model, compare tasks and timeout
`include "ctu_params.svh"

module ctu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import ctu_pkg::*;

   localparam int N_REG  = 60;
   localparam int N_ERR  = 20;
   localparam int N_PIN  = 10;
   localparam int XFER   = 3;
   localparam int IDLE_R = 40;
   localparam int HOLD_P = 1;
   // Reset plus every test's cycles plus margin
   localparam int LIMIT  = 5 + (N_REG + N_ERR + 3) * XFER + 16 * (XFER + IDLE_R)
                         + N_PIN * (XFER + HOLD_P) + 500;

   logic                    cmp_clk = 1'b0;
   logic                    reset;
   apb_req_t                apb_req;
   logic [`CTU_NUM_PIN-1:0] pins;
   logic [31:0]             prdata;
   logic                    pready;
   logic                    pslverr;
   cken_t                   cken_cl;
   cken_t                   cken_jl;
   logic [`CTU_CTRL_W-1:0]  ctrl_jl;
   sync_pulse_t             sync_pulse;
   int                      cycles = 0;

   // ------------------------------
   // Model state
   // ------------------------------
   logic [`CTU_RATIO_W-1:0] m_ratio;
   cken_t                   m_cken;
   logic [`CTU_CTRL_W-1:0]  m_ctrl;
   cken_t                   m_cl;
   cken_t                   m_hold;
   cken_t                   m_jl;
   logic [`CTU_CTRL_W-1:0]  m_hold_ctrl;
   logic [`CTU_CTRL_W-1:0]  m_jl_ctrl;
   logic [`CTU_NUM_PIN-1:0] m_pin1;
   logic [`CTU_NUM_PIN-1:0] m_pin2;
   logic                    m_run;
   int                      m_pos;
   int                      m_per;
   logic                    m_cmd_vld;
   apb_req_t                m_cmd;
   logic                    m_pready;
   logic                    m_err;
   logic [31:0]             m_rd;

   ctu_top UUT (
      .cmp_clk    (cmp_clk),
      .reset      (reset),
      .apb_req    (apb_req),
      .pins       (pins),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .cken_cl    (cken_cl),
      .cken_jl    (cken_jl),
      .ctrl_jl    (ctrl_jl),
      .sync_pulse (sync_pulse)
   );

   always #5 cmp_clk = ~cmp_clk;

   always @(posedge cmp_clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         fail_stop("Timeout: the run went past its cycle limit");
      end
   end

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_cken(input string name, input cken_t got, input cken_t exp);
      if (got !== exp) begin
         fail_stop($sformatf("Mismatch at %0t: %s got 'h%0h expected 'h%0h",
                             $time, name, got, exp));
      end
   endtask

   task automatic check_rd(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_stop($sformatf("Mismatch at %0t: %s got 'h%0h expected 'h%0h",
                             $time, name, got, exp));
      end
   endtask

   task automatic check_ctrl(input string name, input logic [`CTU_CTRL_W-1:0] got,
                             input logic [`CTU_CTRL_W-1:0] exp);
      if (got !== exp) begin
         fail_stop($sformatf("Mismatch at %0t: %s got 'h%0h expected 'h%0h",
                             $time, name, got, exp));
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_stop($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // Ratios 0 and 1 run as 2
   function automatic int clamp_ratio(input logic [`CTU_RATIO_W-1:0] r);
      return (r < 2) ? 2 : int'(r);
   endfunction

   function automatic logic is_mapped(input logic [`CTU_ADDR_W-1:0] a);
      return (a == `CTU_ADDR_RATIO) || (a == `CTU_ADDR_CKEN) ||
             (a == `CTU_ADDR_CTRL) || (a == `CTU_ADDR_STATUS);
   endfunction

   function automatic logic [31:0] read_value(input logic [`CTU_ADDR_W-1:0] a);
      case (a)
         `CTU_ADDR_RATIO:  return 32'(m_ratio);
         `CTU_ADDR_CKEN:   return 32'(m_cken);
         `CTU_ADDR_CTRL:   return 32'(m_ctrl);
         `CTU_ADDR_STATUS: return 32'(m_pin2);
         default:          return '0;
      endcase
   endfunction

   task automatic model_reset();
      m_ratio     = `CTU_RATIO_W'(`CTU_RATIO_RST);
      m_cken      = '0;
      m_ctrl      = '0;
      m_cl        = '0;
      m_hold      = '0;
      m_jl        = '0;
      m_hold_ctrl = '0;
      m_jl_ctrl   = '0;
      m_pin1      = '0;
      m_pin2      = '0;
      m_run       = 1'b0;
      m_pos       = 0;
      m_per       = 2;
      m_cmd_vld   = 1'b0;
      m_cmd       = '0;
      m_pready    = 1'b0;
      m_err       = 1'b0;
      m_rd        = '0;
   endtask

   // One rising edge with every update taken from the values before it
   task automatic model_step();
      logic exp_rx;
      logic exp_coin;
      logic [`CTU_ADDR_W-1:0] a;
      exp_rx   = m_run && (m_pos == 0);
      exp_coin = m_run && (m_pos == m_per - 1);
      // Release before capture
      if (exp_coin) begin
         m_jl      = m_hold;
         m_jl_ctrl = m_hold_ctrl;
      end
      if (exp_rx) begin
         m_hold      = m_cl;
         m_hold_ctrl = m_ctrl;
      end
      // Force wins over start and neither gives zero
      if (m_ctrl[`CTU_CTRL_FORCE_BIT]) begin
         m_cl = '1;
      end else if (m_ctrl[`CTU_CTRL_START_BIT]) begin
         m_cl = m_cken;
      end else begin
         m_cl = '0;
      end
      // New period picks up the ratio
      if (!m_run || exp_coin) begin
         m_run = 1'b1;
         m_pos = 0;
         m_per = clamp_ratio(m_ratio);
      end else begin
         m_pos++;
      end
      m_pready = m_cmd_vld;
      m_err    = 1'b0;
      if (m_cmd_vld) begin
         a     = m_cmd.paddr;
         m_err = !is_mapped(a) || (m_cmd.pwrite && (a == `CTU_ADDR_STATUS));
         m_rd  = read_value(a);
         if (m_cmd.pwrite) begin
            case (a)
               `CTU_ADDR_RATIO: m_ratio = m_cmd.pwdata[`CTU_RATIO_W-1:0];
               `CTU_ADDR_CKEN:  m_cken  = m_cmd.pwdata[`CTU_NUM_CKEN-1:0];
               `CTU_ADDR_CTRL:  m_ctrl  = m_cmd.pwdata[`CTU_CTRL_W-1:0];
               default:         ;
            endcase
         end
      end
      // Setup cycle seen at this edge
      m_cmd_vld = apb_req.psel && !apb_req.penable;
      m_cmd     = apb_req;
      m_pin2    = m_pin1;
      m_pin1    = pins;
   endtask

   task automatic compare_all();
      check_err("pready", pready, m_pready);
      check_err("pslverr", pslverr, m_err);
      check_err("rx_sync", sync_pulse.rx_sync, m_run && (m_pos == 0));
      check_err("coin_edge", sync_pulse.coin_edge, m_run && (m_pos == m_per - 1));
      check_cken("cken_cl", cken_cl, m_cl);
      check_cken("cken_jl", cken_jl, m_jl);
      check_ctrl("ctrl_jl", ctrl_jl, m_jl_ctrl);
   endtask

   // Inputs already set on this falling edge
   task automatic tick();
      model_step();
      @(negedge cmp_clk);
      compare_all();
   endtask

   task automatic apb_xfer(input logic wr, input logic [`CTU_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      int n;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      tick();
      apb_req.penable = 1'b1;
      tick();
      n = 1;
      while (!pready && n < 8) begin
         tick();
         n++;
      end
      if (!pready) begin
         fail_stop("APB slave gave no pready within 8 cycles");
      end
      if (n != 1) begin
         fail_stop("pready did not come after exactly one wait state");
      end
      if (!wr) begin
         check_rd("prdata", prdata, m_rd);
      end
      rdata   = prdata;
      err     = pslverr;
      apb_req = '0;
      tick();
   endtask

   initial begin
      logic [31:0]            rd;
      logic                   err;
      logic                   wr;
      logic [`CTU_ADDR_W-1:0] addr;
      logic [`CTU_RATIO_W-1:0] r;
      int                     k;
      apb_req = '0;
      pins    = '0;
      reset   = 1'b1;
      void'($urandom(88));
      model_reset();
      repeat (5) @(negedge cmp_clk);
      reset = 1'b0;

      // ------------------------------
      // Register writes and reads
      // ------------------------------
      for (int i = 0; i < N_REG; i++) begin
         k  = int'($urandom_range(2, 0));
         wr = 1'($urandom_range(1, 0));
         case (k)
            0:       addr = `CTU_ADDR_RATIO;
            1:       addr = `CTU_ADDR_CKEN;
            default: addr = `CTU_ADDR_CTRL;
         endcase
         apb_xfer(wr, addr, $urandom(), rd, err);
         check_err("pslverr", err, 1'b0);
      end

      // Illegal writes and unmapped reads
      for (int i = 0; i < N_ERR; i++) begin
         k         = int'($urandom_range(2, 0));
         addr      = `CTU_ADDR_W'($urandom());
         addr[1:0] = 2'($urandom_range(3, 1));
         if (k == 0) begin
            addr = `CTU_ADDR_STATUS;
         end
         wr = (k != 2);
         apb_xfer(wr, addr, $urandom(), rd, err);
         check_err("pslverr", err, 1'b1);
         if (!wr) begin
            check_rd("prdata", rd, '0);
         end
      end
      // Readback shows nothing was touched
      apb_xfer(1'b0, `CTU_ADDR_RATIO, '0, rd, err);
      apb_xfer(1'b0, `CTU_ADDR_CKEN, '0, rd, err);
      apb_xfer(1'b0, `CTU_ADDR_CTRL, '0, rd, err);

      // Pulse spacing per ratio with 0 and 1 first
      for (int i = 0; i < 16; i++) begin
         r = (i < 2) ? `CTU_RATIO_W'(i) : `CTU_RATIO_W'($urandom());
         apb_xfer(1'b1, `CTU_ADDR_RATIO, 32'(r), rd, err);
         repeat (IDLE_R) tick();
      end

      // ------------------------------
      // Pins through the synchronizer
      // ------------------------------
      for (int i = 0; i < N_PIN; i++) begin
         pins = `CTU_NUM_PIN'($urandom());
         repeat (HOLD_P) tick();
         apb_xfer(1'b0, `CTU_ADDR_STATUS, '0, rd, err);
         check_rd("status", rd, 32'(pins));
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* src.f */
+incdir+.
ctu_pkg.sv
ctu_sync_pulse_gen.sv
ctu_synch_stage.sv
ctu_synchronizer.sv
ctu_apb_decode.sv
ctu_cken_ctl.sv
ctu_status_rd.sv
ctu_top.sv
ctu_asserts.sv
ctu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CTU testbench with Verilator, result taken from the log
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module ctu_tb \
   -o ctu_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ctu_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
